/* bench/tb_soc_fabric.sv */
`timescale 1ns/1ps

module tb_soc_fabric
	import bus_pkg::*;
	import map_pkg::*;
();
	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int RAM_OPS      = 12;
	localparam int REQ_CYCLES   = 12;  // Generous per-request allowance
	localparam int STALL_CYCLES = 24;
	localparam int CREDIT_REQS  = REQ_DEPTH + RSP_DEPTH + HOST_RSP_CREDITS;  // Fills every buffer
	// Cycle budgets per test
	localparam int RAM_BUDGET    = 3 * RAM_OPS * REQ_CYCLES;
	localparam int NONE_BUDGET   = 8 * REQ_CYCLES;
	localparam int UART_BUDGET   = 2 * FRAME_BITS * CLKS_PER_BIT + 5 * REQ_CYCLES;
	localparam int CREDIT_BUDGET = STALL_CYCLES + CREDIT_REQS * REQ_CYCLES;
	localparam int WATCHDOG_CYCLES =
		2 * (RESET_CYCLES + RAM_BUDGET + NONE_BUDGET + UART_BUDGET + CREDIT_BUDGET);
	// Just past the RAM, past the UART block, top of the low 64K, far away
	localparam logic [31:0] BAD_ADDR [4] = '{32'h0000_0400, 32'h0001_0008,
		32'h0000_FFFC, 32'h8000_0000};

	logic     clk;
	logic     reset_i;
	logic     req_valid_i;
	bus_req_t req_i;
	logic     req_credit_o;
	logic     rsp_valid_o;
	bus_rsp_t rsp_o;
	logic     rsp_credit_i;
	logic     tx_o;

	int          mismatch_errors = 0;
	int          other_errors    = 0;
	int          req_credits     = REQ_DEPTH;  // Requester side credit count
	int          credit_pulses   = 0;
	int          sent_count      = 0;
	int          host_in_use     = 0;  // Response slots held by the requester
	int          held_rsp_count  = 0;
	int          rx_frames       = 0;
	logic        hold_credits;
	bus_rsp_t    exp_q [$];            // Expected responses in request order
	bus_rsp_t    exp_rsp;
	logic [7:0]  uart_exp_q [$];
	logic [7:0]  rx_byte;
	logic [DATA_W-1:0] shadow_ram [RAM_WORDS];
	logic [RAM_AW-1:0] used_idx [RAM_OPS];   // Words with known contents

	soc_fabric dut (
		.clk_i(clk),
		.reset_i(reset_i),
		.req_valid_i(req_valid_i),
		.req_i(req_i),
		.req_credit_o(req_credit_o),
		.rsp_valid_o(rsp_valid_o),
		.rsp_o(rsp_o),
		.rsp_credit_i(rsp_credit_i),
		.tx_o(tx_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Port state while reset is held
	a_reset_quiet: assert property (@(negedge clk)
		reset_i |-> (!rsp_valid_o && !req_credit_o && tx_o === 1'b1))
	else begin
		mismatch_errors++;
		$display("MISMATCH during reset rsp_valid_o %h req_credit_o %h tx_o %h, expected 0 0 1",
			rsp_valid_o, req_credit_o, tx_o);
	end

	a_host_slots: assert property (@(negedge clk) disable iff (reset_i)
		rsp_valid_o |-> (host_in_use < HOST_RSP_CREDITS))
	else begin
		other_errors++;
		$display("Response sent while the requester had no free response slot");
	end

	a_req_credit_range: assert property (@(negedge clk)
		(req_credits >= 0) && (req_credits <= REQ_DEPTH))
	else begin
		other_errors++;
		$display("Requester credit count left the range of the request buffer");
	end

	// Credit pulses and response checks, sampled mid cycle
	always @(negedge clk) begin
		if (!reset_i) begin
			if (req_credit_o) begin
				req_credits++;
				credit_pulses++;
			end
			if (rsp_valid_o) begin
				host_in_use++;
				if (hold_credits)
					held_rsp_count++;
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("Response arrived with no request outstanding");
				end else begin
					exp_rsp = exp_q.pop_front();
					assert (rsp_o.err == exp_rsp.err) else begin
						mismatch_errors++;
						$display("MISMATCH rsp_o.err expected %h actual %h", exp_rsp.err, rsp_o.err);
					end
					assert (rsp_o.rdata == exp_rsp.rdata) else begin
						mismatch_errors++;
						$display("MISMATCH rsp_o.rdata expected %h actual %h",
							exp_rsp.rdata, rsp_o.rdata);
					end
				end
			end
		end
	end

	// Requester frees response slots after random gaps
	initial begin
		rsp_credit_i = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (!reset_i && !hold_credits && host_in_use > 0 && $urandom_range(2) != 0) begin
				rsp_credit_i = 1'b1;
				host_in_use--;
			end else begin
				rsp_credit_i = 1'b0;
			end
		end
	end

	// Serial receiver, samples at negedges near mid bit
	initial begin
		forever begin
			@(negedge tx_o);
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			assert (tx_o == 1'b0) else begin
				other_errors++;
				$display("UART start bit was not low at mid bit");
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				rx_byte[i] = tx_o;  // LSB first
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			assert (tx_o == 1'b1) else begin
				other_errors++;
				$display("UART stop bit was not high at mid bit");
			end
			if (uart_exp_q.size() == 0) begin
				other_errors++;
				$display("UART frame received with no byte written");
			end else begin
				assert (rx_byte == uart_exp_q[0]) else begin
					mismatch_errors++;
					$display("MISMATCH tx_o byte expected %h actual %h", uart_exp_q[0], rx_byte);
				end
				void'(uart_exp_q.pop_front());
			end
			rx_frames++;
		end
	end

	function automatic bus_req_t make_req(input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb);
		bus_req_t r;
		r.write = wr;
		r.addr  = addr;
		r.wdata = wdata;
		r.wstrb = wstrb;
		return r;
	endfunction

	// Random low bits, which the map ignores
	function automatic logic [ADDR_W-1:0] ram_addr(input logic [RAM_AW-1:0] idx);
		return {{(ADDR_W-RAM_AW-2){1'b0}}, idx, 2'($urandom)};
	endfunction

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	// Called at 1 ns past an edge, returns the same way
	task automatic send_req(input bus_req_t req, input logic exp_err,
		input logic [DATA_W-1:0] exp_rdata);
		bus_rsp_t exp;
		while (req_credits == 0) begin
			req_valid_i = 1'b0;
			@(posedge clk);
			#1;
		end
		exp.err   = exp_err;
		exp.rdata = exp_rdata;
		exp_q.push_back(exp);
		req_valid_i = 1'b1;
		req_i       = req;
		req_credits--;
		sent_count++;
		@(posedge clk);
		#1;
		req_valid_i = 1'b0;
	endtask

	// All responses in and every slot handed back
	task automatic wait_drain();
		while (exp_q.size() != 0 || host_in_use != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic ram_traffic();
		logic [RAM_AW-1:0] idx;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		for (int i = 0; i < RAM_OPS; i++) begin
			idx         = RAM_AW'($urandom_range(RAM_WORDS - 1));
			used_idx[i] = idx;
			data        = $urandom;
			shadow_ram[idx] = data;  // Full word, so later reads are known
			send_req(make_req(1'b1, ram_addr(idx), data, '1), 1'b0, '0);
		end
		for (int i = 0; i < RAM_OPS; i++) begin
			idx  = used_idx[$urandom_range(RAM_OPS - 1)];
			data = $urandom;
			strb = STRB_W'($urandom);
			shadow_ram[idx] = merge_bytes(shadow_ram[idx], data, strb);
			send_req(make_req(1'b1, ram_addr(idx), data, strb), 1'b0, '0);
		end
		for (int i = 0; i < RAM_OPS; i++)
			send_req(make_req(1'b0, ram_addr(used_idx[i]), $urandom, '0), 1'b0,
				shadow_ram[used_idx[i]]);
		wait_drain();
	endtask

	task automatic unmapped_access();
		for (int i = 0; i < 4; i++) begin
			send_req(make_req(1'b0, BAD_ADDR[i], '0, '0), 1'b1, '0);
			send_req(make_req(1'b1, BAD_ADDR[i], $urandom, '1), 1'b1, '0);
		end
		wait_drain();
	endtask

	task automatic uart_frames();
		logic [7:0] first_b;
		logic [7:0] second_b;
		first_b  = 8'($urandom);
		second_b = 8'($urandom);
		uart_exp_q.push_back(first_b);
		uart_exp_q.push_back(second_b);
		send_req(make_req(1'b1, UART_BASE + UART_DATA_OFS, {24'($urandom), first_b}, '1),
			1'b0, '0);
		send_req(make_req(1'b0, UART_BASE + UART_STAT_OFS, '0, '0), 1'b0, 32'h1);  // Busy
		send_req(make_req(1'b1, UART_BASE + UART_STAT_OFS, $urandom, '1), 1'b0, '0);
		send_req(make_req(1'b1, UART_BASE + UART_DATA_OFS, {24'h0, second_b}, '1), 1'b0, '0);
		send_req(make_req(1'b0, UART_BASE + UART_DATA_OFS, '0, '0), 1'b0, {24'h0, second_b});
		while (rx_frames < 2) begin
			@(posedge clk);
			#1;
		end
		wait_drain();
	endtask

	// Withhold slots until every buffer is full, then release
	task automatic credit_stall();
		logic [RAM_AW-1:0] idx;
		hold_credits   = 1'b1;
		held_rsp_count = 0;
		for (int i = 0; i < CREDIT_REQS; i++) begin
			idx = used_idx[$urandom_range(RAM_OPS - 1)];
			send_req(make_req(1'b0, ram_addr(idx), '0, '0), 1'b0, shadow_ram[idx]);
		end
		repeat (STALL_CYCLES) @(posedge clk);
		#1;
		assert (held_rsp_count <= HOST_RSP_CREDITS) else begin
			other_errors++;
			$display("More responses than response slots while credits were withheld");
		end
		assert (req_credits == 0) else begin
			mismatch_errors++;
			$display("MISMATCH requester credits while stalled expected %h actual %h",
				0, req_credits);
		end
		hold_credits = 1'b0;
		wait_drain();
	endtask

	initial begin
		void'($urandom(32'h2bfd));
		reset_i      = 1'b1;
		req_valid_i  = 1'b0;
		req_i        = '0;
		hold_credits = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_i = 1'b0;
		ram_traffic();
		unmapped_access();
		uart_frames();
		credit_stall();
		assert (credit_pulses == sent_count) else begin
			mismatch_errors++;
			$display("MISMATCH req_credit_o pulses expected %h actual %h", sent_count,
				credit_pulses);
		end
		assert (req_credits == REQ_DEPTH) else begin
			mismatch_errors++;
			$display("MISMATCH final requester credits expected %h actual %h", REQ_DEPTH,
				req_credits);
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		other_errors++;
		$display("Watchdog expired before the tests finished");
		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		$display("Test failures found");
		$finish;
	end

endmodule

/* src.f */
verilog/bus_pkg.sv
verilog/map_pkg.sv
verilog/credit_fifo.sv
verilog/req_decode.sv
verilog/ram_bank.sv
verilog/uart_tx.sv
verilog/rsp_return.sv
verilog/soc_fabric.sv
bench/tb_soc_fabric.sv

/* verilog/bus_pkg.sv */
package bus_pkg;

	// Transport widths
	localparam int ADDR_W = 32;          // Byte address
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;  // One strobe per byte lane

	// Credit depths
	localparam int REQ_DEPTH        = 4;  // Also the requester's initial credits
	localparam int RSP_DEPTH        = 4;
	localparam int HOST_RSP_CREDITS = 2;  // Response slots on the requester side

	// Counter widths for the credit counters
	localparam int RSP_CRED_W  = $clog2(RSP_DEPTH + 1);
	localparam int HOST_CRED_W = $clog2(HOST_RSP_CREDITS + 1);

	// Request as it travels through the fabric
	typedef struct packed {
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] wstrb;
	} bus_req_t;

	// Response back to the requester
	typedef struct packed {
		logic              err;    // Unmapped address
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

endpackage

/* verilog/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo
	import bus_pkg::*;
#(
	parameter type T     = bus_req_t,
	parameter int  DEPTH = REQ_DEPTH
) (
	input  logic clk_i,
	input  logic reset_i,
	input  logic push_i,
	input  T     data_i,
	input  logic pop_i,
	output logic valid_o,
	output T     data_o,
	output logic credit_o  // One pulse per entry freed
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;   // Occupancy
	logic             do_pop;

	// Wrap at DEPTH, also for non power of two depths
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign valid_o = (count_q != '0);
	assign data_o  = mem[rd_ptr_q];     // Head is always on the output
	assign do_pop  = pop_i && valid_o;

	always_ff @(posedge clk_i) begin
		if (push_i)
			mem[wr_ptr_q] <= data_i;
	end

	// Pointers, count and credit pulse
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_o <= 1'b0;
		end else begin
			credit_o <= do_pop;  // Cycle after the pop
			if (push_i)
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			case ({push_i, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;  // Both or neither
			endcase
		end
	end

endmodule

/* verilog/map_pkg.sv */
package map_pkg;

	// RAM at the bottom of the map, bytes 0x0000 to 0x03FF
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = $clog2(RAM_WORDS);  // Word index bits

	// UART register block
	localparam logic [31:0] UART_BASE     = 32'h0001_0000;
	localparam logic [31:0] UART_DATA_OFS = 32'h0;  // Tx byte, reads back last byte
	localparam logic [31:0] UART_STAT_OFS = 32'h4;  // Bit 0 is busy

	// Serial timing
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_W       = $clog2(CLKS_PER_BIT);
	localparam int FRAME_BITS   = 10;  // Start, 8 data, stop
	localparam int FRAME_CNT_W  = $clog2(FRAME_BITS);

	// Read data returned for an unmapped access
	localparam logic [31:0] NONE_RDATA = 32'h0;

	// Decoded destination of a request
	typedef enum logic [1:0] {
		TGT_RAM,
		TGT_UART,
		TGT_NONE
	} target_e;

endpackage

/* verilog/ram_bank.sv */
`timescale 1ns/1ps

module ram_bank
	import bus_pkg::*;
	import map_pkg::*;
(
	input  logic     clk_i,
	input  logic     reset_i,
	input  logic     issue_i,
	input  bus_req_t req_i,
	output logic     rsp_valid_o,
	output bus_rsp_t rsp_o
);
	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [RAM_AW-1:0] idx;

	assign idx = req_i.addr[RAM_AW+1:2];  // Word address

	// Byte lane writes
	always_ff @(posedge clk_i) begin
		if (issue_i && req_i.write) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (req_i.wstrb[b])
					mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
			end
		end
	end

	// Response one cycle after issue, old word on a read
	always_ff @(posedge clk_i) begin
		if (issue_i) begin
			rsp_o.err   <= 1'b0;
			rsp_o.rdata <= req_i.write ? '0 : mem[idx];
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			rsp_valid_o <= 1'b0;
		else
			rsp_valid_o <= issue_i;
	end

endmodule

/* verilog/req_decode.sv */
`timescale 1ns/1ps

module req_decode
	import bus_pkg::*;
	import map_pkg::*;
(
	input  logic     clk_i,
	input  logic     reset_i,
	// Request buffer head
	input  logic     head_valid_i,
	input  bus_req_t head_i,
	output logic     pop_o,
	// Flow control
	input  logic     rsp_credit_i,  // Response buffer slot freed
	input  logic     uart_ready_i,
	// Issue towards the targets
	output logic     ram_issue_o,
	output logic     uart_issue_o,
	output logic     none_issue_o,
	output bus_req_t issue_req_o
);
	target_e               tgt;
	logic                  is_ram;
	logic                  is_uart_data;
	logic                  is_uart_stat;
	logic                  uart_hold;
	logic [RSP_CRED_W-1:0] rsp_cred_q;

	// Low two address bits play no part in the decode
	assign is_ram       = (head_i.addr[ADDR_W-1:RAM_AW+2] == '0);
	assign is_uart_data = ({head_i.addr[ADDR_W-1:2], 2'b00} == UART_BASE + UART_DATA_OFS);
	assign is_uart_stat = ({head_i.addr[ADDR_W-1:2], 2'b00} == UART_BASE + UART_STAT_OFS);

	always_comb begin
		if (is_ram)
			tgt = TGT_RAM;
		else if (is_uart_data || is_uart_stat)
			tgt = TGT_UART;
		else
			tgt = TGT_NONE;  // Error response later
	end

	// Only a new Tx byte has to wait for the shifter
	assign uart_hold = is_uart_data && head_i.write && !uart_ready_i;

	// Pop and issue in the same cycle
	assign pop_o = head_valid_i && (rsp_cred_q != '0) && !uart_hold;

	assign ram_issue_o  = pop_o && (tgt == TGT_RAM);
	assign uart_issue_o = pop_o && (tgt == TGT_UART);
	assign none_issue_o = pop_o && (tgt == TGT_NONE);
	assign issue_req_o  = head_i;  // Same payload for every target

	// Response buffer credits, one held per request in flight
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rsp_cred_q <= RSP_CRED_W'(RSP_DEPTH);
		end else begin
			case ({pop_o, rsp_credit_i})
				2'b10:   rsp_cred_q <= rsp_cred_q - 1'b1;
				2'b01:   rsp_cred_q <= rsp_cred_q + 1'b1;
				default: rsp_cred_q <= rsp_cred_q;
			endcase
		end
	end

endmodule

/* verilog/rsp_return.sv */
`timescale 1ns/1ps

module rsp_return
	import bus_pkg::*;
	import map_pkg::*;
(
	input  logic     clk_i,
	input  logic     reset_i,
	// Target responses
	input  logic     ram_valid_i,
	input  bus_rsp_t ram_rsp_i,
	input  logic     uart_valid_i,
	input  bus_rsp_t uart_rsp_i,
	input  logic     none_issue_i,
	output logic     rsp_credit_o,   // Back to req_decode
	// Outbound port
	input  logic     host_credit_i,
	output logic     rsp_valid_o,
	output bus_rsp_t rsp_o
);
	logic                   none_q;
	logic                   push;
	bus_rsp_t               push_rsp;
	logic                   head_valid;
	bus_rsp_t               head_rsp;
	logic                   pop;
	logic [HOST_CRED_W-1:0] host_cred_q;

	// Unmapped access answers in the same slot as a target would
	always_ff @(posedge clk_i) begin
		if (reset_i)
			none_q <= 1'b0;
		else
			none_q <= none_issue_i;
	end

	// One issue per cycle, so at most one source is valid
	assign push = ram_valid_i || uart_valid_i || none_q;

	always_comb begin
		if (ram_valid_i) begin
			push_rsp = ram_rsp_i;
		end else if (uart_valid_i) begin
			push_rsp = uart_rsp_i;
		end else begin
			push_rsp.err   = 1'b1;
			push_rsp.rdata = NONE_RDATA;
		end
	end

	credit_fifo #(
		.T(bus_rsp_t),
		.DEPTH(RSP_DEPTH)
	) inst_rsp_fifo (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.push_i(push),
		.data_i(push_rsp),
		.pop_i(pop),
		.valid_o(head_valid),
		.data_o(head_rsp),
		.credit_o(rsp_credit_o)
	);

	assign pop = head_valid && (host_cred_q != '0);

	// Requester slots, spent on pop
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			host_cred_q <= HOST_CRED_W'(HOST_RSP_CREDITS);
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= pop;
			case ({pop, host_credit_i})
				2'b10:   host_cred_q <= host_cred_q - 1'b1;
				2'b01:   host_cred_q <= host_cred_q + 1'b1;
				default: host_cred_q <= host_cred_q;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (pop)
			rsp_o <= head_rsp;  // Registered output port
	end

endmodule

/* verilog/soc_fabric.sv */
`timescale 1ns/1ps

module soc_fabric
	import bus_pkg::*;
(
	input  logic     clk_i,
	input  logic     reset_i,
	// Request port
	input  logic     req_valid_i,
	input  bus_req_t req_i,
	output logic     req_credit_o,
	// Response port
	output logic     rsp_valid_o,
	output bus_rsp_t rsp_o,
	input  logic     rsp_credit_i,
	// UART
	output logic     tx_o
);
	// Request buffer to decode
	logic     req_head_valid_s, req_pop_s;
	bus_req_t req_head_s;
	// Decode to targets
	logic     ram_issue_s, uart_issue_s, none_issue_s;
	bus_req_t issue_req_s;
	logic     uart_ready_s, rsp_credit_s;
	// Targets to return stage
	logic     ram_rsp_valid_s, uart_rsp_valid_s;
	bus_rsp_t ram_rsp_s, uart_rsp_s;

	credit_fifo #(
		.T(bus_req_t),
		.DEPTH(REQ_DEPTH)
	) inst_req_fifo (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.push_i(req_valid_i),
		.data_i(req_i),
		.pop_i(req_pop_s),
		.valid_o(req_head_valid_s),
		.data_o(req_head_s),
		.credit_o(req_credit_o)
	);

	req_decode inst_req_decode (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.head_valid_i(req_head_valid_s),
		.head_i(req_head_s),
		.pop_o(req_pop_s),
		.rsp_credit_i(rsp_credit_s),
		.uart_ready_i(uart_ready_s),
		.ram_issue_o(ram_issue_s),
		.uart_issue_o(uart_issue_s),
		.none_issue_o(none_issue_s),
		.issue_req_o(issue_req_s)
	);

	ram_bank inst_ram_bank (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.issue_i(ram_issue_s),
		.req_i(issue_req_s),
		.rsp_valid_o(ram_rsp_valid_s),
		.rsp_o(ram_rsp_s)
	);

	uart_tx inst_uart_tx (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.issue_i(uart_issue_s),
		.req_i(issue_req_s),
		.ready_o(uart_ready_s),
		.rsp_valid_o(uart_rsp_valid_s),
		.rsp_o(uart_rsp_s),
		.tx_o(tx_o)
	);

	rsp_return inst_rsp_return (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ram_valid_i(ram_rsp_valid_s),
		.ram_rsp_i(ram_rsp_s),
		.uart_valid_i(uart_rsp_valid_s),
		.uart_rsp_i(uart_rsp_s),
		.none_issue_i(none_issue_s),
		.rsp_credit_o(rsp_credit_s),
		.host_credit_i(rsp_credit_i),
		.rsp_valid_o(rsp_valid_o),
		.rsp_o(rsp_o)
	);

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
	import bus_pkg::*;
	import map_pkg::*;
(
	input  logic     clk_i,
	input  logic     reset_i,
	input  logic     issue_i,
	input  bus_req_t req_i,
	output logic     ready_o,      // Low while a frame is on the line
	output logic     rsp_valid_o,
	output bus_rsp_t rsp_o,
	output logic     tx_o
);
	logic                   busy_q;
	logic [FRAME_BITS-1:0]  shift_q;     // Stop, data, start with LSB on the line
	logic [FRAME_CNT_W-1:0] bit_cnt_q;
	logic [BAUD_W-1:0]      baud_cnt_q;
	logic [7:0]             last_byte_q;
	logic                   is_stat;
	logic                   data_wr;

	// Decoder only lets the two register offsets through
	assign is_stat = (req_i.addr[3:2] == UART_STAT_OFS[3:2]);
	assign data_wr = issue_i && req_i.write && !is_stat;

	assign ready_o = !busy_q;
	assign tx_o    = busy_q ? shift_q[0] : 1'b1;  // Idle high

	// Frame shifter and baud timing
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q     <= 1'b0;
			bit_cnt_q  <= '0;
			baud_cnt_q <= '0;
		end else if (data_wr) begin
			busy_q     <= 1'b1;
			bit_cnt_q  <= '0;
			baud_cnt_q <= '0;
		end else if (busy_q) begin
			if (baud_cnt_q == BAUD_W'(CLKS_PER_BIT - 1)) begin
				baud_cnt_q <= '0;
				if (bit_cnt_q == FRAME_CNT_W'(FRAME_BITS - 1))
					busy_q <= 1'b0;  // Stop bit done
				else
					bit_cnt_q <= bit_cnt_q + 1'b1;
			end else begin
				baud_cnt_q <= baud_cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (data_wr)
			shift_q <= {1'b1, req_i.wdata[7:0], 1'b0};
		else if (busy_q && baud_cnt_q == BAUD_W'(CLKS_PER_BIT - 1))
			shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
	end

	// Register file and response
	always_ff @(posedge clk_i) begin
		if (data_wr)
			last_byte_q <= req_i.wdata[7:0];
		if (issue_i) begin
			rsp_o.err <= 1'b0;
			if (req_i.write)
				rsp_o.rdata <= '0;  // Status write dropped
			else if (is_stat)
				rsp_o.rdata <= DATA_W'(busy_q);
			else
				rsp_o.rdata <= {{(DATA_W-8){1'b0}}, last_byte_q};
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			rsp_valid_o <= 1'b0;
		else
			rsp_valid_o <= issue_i;
	end

endmodule
